// File: bench/ram_model.sv
// byte-wide RAM for the testbench, one-cycle read latency and a counter of RAM reads
`timescale 1ns/1ps
`include "mem_consts.svh"

module ram_model (
  input  logic                    clk_in,
  input  logic                    en,        // pauses together with the DUT
  input  logic [`ADDR_WIDTH-1:0]  mem_a,
  input  logic                    mem_wr,
  input  logic [`BYTE_WIDTH-1:0]  mem_dout,
  output logic [`BYTE_WIDTH-1:0]  mem_din
);
  localparam int RAM_BYTES = 1 << `RAM_ADDR_WIDTH;

  logic [`BYTE_WIDTH-1:0]     mem [RAM_BYTES];
  logic [`RAM_ADDR_WIDTH-1:0] addr;
  logic [`RAM_ADDR_WIDTH-1:0] last_addr;
  int unsigned                read_count;  // reads of a new address

  assign addr = mem_a[`RAM_ADDR_WIDTH-1:0];

  initial begin
    // every address bit folds into the byte value
    for (int i = 0; i < RAM_BYTES; i++) begin
      mem[i] = 8'(i * 7 + 3) ^ 8'(i >> 8) ^ 8'(i >> 16);
    end
    mem_din    = '0;
    last_addr  = '0;
    read_count = 0;
  end

  always @(posedge clk_in) begin
    if (en) begin
      mem_din <= mem[addr];  // old contents, data shows one cycle later
      if (!mem_wr && addr != last_addr) read_count <= read_count + 1;
      last_addr <= addr;
      if (mem_wr) mem[addr] = mem_dout;
    end
  end

endmodule

// File: bench/tb_mem_subsystem.sv
// testbench for the memory subsystem, applies a table of fetch and load/store entries
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_subsystem;
  import mem_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int DONE_TIMEOUT = 40;  // cycles allowed per entry
  localparam int RAM_BYTES    = 1 << `RAM_ADDR_WIDTH;

  typedef enum logic [1:0] {FETCH, LOAD_STORE, BOTH, FROZEN} kind_t;

  typedef struct packed {
    kind_t                  kind;
    ls_op_t                 op;
    logic [`ADDR_WIDTH-1:0] f_addr;
    logic [`ADDR_WIDTH-1:0] l_addr;
    logic [`WORD_WIDTH-1:0] wdata;
    logic                   hit;   // fetch expected to hit the cache
  } stim_t;

  logic                   clk_in;
  logic                   rst_in;
  logic                   rdy_in;
  logic                   fetch_en;
  logic [`ADDR_WIDTH-1:0] fetch_addr;
  logic                   fetch_done;
  logic [`WORD_WIDTH-1:0] fetch_data;
  logic                   ls_en;
  ls_op_t                 ls_op;
  logic [`ADDR_WIDTH-1:0] ls_addr;
  logic [`WORD_WIDTH-1:0] ls_wdata;
  logic                   ls_done;
  logic [`WORD_WIDTH-1:0] ls_rdata;
  logic [`BYTE_WIDTH-1:0] mem_din;
  logic [`BYTE_WIDTH-1:0] mem_dout;
  logic [`ADDR_WIDTH-1:0] mem_a;
  logic                   mem_wr;

  logic [`BYTE_WIDTH-1:0] shadow [RAM_BYTES];  // expected RAM contents
  stim_t                  stim [$];
  bit                     table_ready;
  int                     seed;
  int                     errors;
  int                     checks;

  mem_subsystem mem_subsystem_inst (.*);

  ram_model ram_model_inst (
    .clk_in   (clk_in),
    .en       (rdy_in),
    .mem_a    (mem_a),
    .mem_wr   (mem_wr),
    .mem_dout (mem_dout),
    .mem_din  (mem_din)
  );

  initial clk_in = 1'b0;
  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  // preload value of a RAM byte
  function automatic logic [7:0] rule_byte(input int unsigned a);
    int unsigned v;
    v = a * 7 + 3;
    return v[7:0] ^ a[15:8] ^ {6'd0, a[17:16]};
  endfunction

  function automatic logic [7:0] shadow_at(input logic [`ADDR_WIDTH-1:0] a);
    return shadow[a[`RAM_ADDR_WIDTH-1:0]];
  endfunction

  function automatic logic [31:0] word_at(input logic [`ADDR_WIDTH-1:0] a);
    return {shadow_at(a + 3), shadow_at(a + 2), shadow_at(a + 1), shadow_at(a)};
  endfunction

  function automatic logic [31:0] expected_load(input ls_op_t op, input logic [31:0] a);
    logic [31:0] w;
    w = word_at(a);
    case (op)
      LB:      return 32'($signed(w[7:0]));
      LH:      return 32'($signed(w[15:0]));
      LW:      return w;
      LBU:     return {24'd0, w[7:0]};
      LHU:     return {16'd0, w[15:0]};
      default: return 32'd0;  // stores give zero
    endcase
  endfunction

  function automatic int store_bytes(input ls_op_t op);
    return (op == SB) ? 1 : (op == SH) ? 2 : (op == SW) ? 4 : 0;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic add_entry(input kind_t k, input ls_op_t op, input logic [31:0] fa,
                           input logic [31:0] la, input logic hit);
    stim_t s;
    s.kind   = k;
    s.op     = op;
    s.f_addr = fa;
    s.l_addr = la;
    s.wdata  = $random(seed);
    s.hit    = hit;
    stim.push_back(s);
  endtask

  task automatic build_stimulus();
    add_entry(FETCH, LB, 32'h1000, 32'h0, 1'b0);       // cold miss
    add_entry(FETCH, LB, 32'h1004, 32'h0, 1'b1);       // other word, same block
    add_entry(FETCH, LB, 32'h1000, 32'h0, 1'b1);
    add_entry(FETCH, LB, 32'h11fc, 32'h0, 1'b0);
    add_entry(FETCH, LB, 32'h11f8, 32'h0, 1'b1);
    add_entry(LOAD_STORE, LB, 32'h0, 32'h2003, 1'b0);
    add_entry(LOAD_STORE, LB, 32'h0, 32'h2085, 1'b0);  // negative byte
    add_entry(LOAD_STORE, LH, 32'h0, 32'h2006, 1'b0);
    add_entry(LOAD_STORE, LH, 32'h0, 32'h2090, 1'b0);  // negative half
    add_entry(LOAD_STORE, LW, 32'h0, 32'h2008, 1'b0);
    add_entry(LOAD_STORE, LBU, 32'h0, 32'h2085, 1'b0);
    add_entry(LOAD_STORE, LHU, 32'h0, 32'h2012, 1'b0);
    add_entry(LOAD_STORE, SB, 32'h0, 32'h2021, 1'b0);
    add_entry(LOAD_STORE, LW, 32'h0, 32'h2020, 1'b0);
    add_entry(LOAD_STORE, SH, 32'h0, 32'h2032, 1'b0);
    add_entry(LOAD_STORE, LW, 32'h0, 32'h2030, 1'b0);
    add_entry(LOAD_STORE, SW, 32'h0, 32'h2040, 1'b0);
    add_entry(LOAD_STORE, LW, 32'h0, 32'h2040, 1'b0);
    add_entry(LOAD_STORE, LW, 32'h0, 32'h2043, 1'b0);  // straddles the store
    add_entry(LOAD_STORE, LHU, 32'h0, 32'h2032, 1'b0);
    add_entry(BOTH, LW, 32'h1300, 32'h2044, 1'b0);
    add_entry(BOTH, LBU, 32'h1304, 32'h2021, 1'b1);
    add_entry(BOTH, SW, 32'h1400, 32'h2050, 1'b0);
    add_entry(FROZEN, LW, 32'h0, 32'h2060, 1'b0);
    add_entry(FROZEN, LH, 32'h0, 32'h2072, 1'b0);
    add_entry(FETCH, LB, 32'h1008, 32'h0, 1'b0);
  endtask

  // samples at falling edges, the current edge counts as cycle 0
  task automatic wait_for_done(input logic need_f, input logic need_l,
                               output int f_cyc, output int l_cyc);
    f_cyc = -1;
    l_cyc = -1;
    for (int c = 0; c < DONE_TIMEOUT; c++) begin
      if (fetch_done && f_cyc < 0) f_cyc = c;
      if (ls_done && l_cyc < 0) l_cyc = c;
      if ((!need_f || f_cyc >= 0) && (!need_l || l_cyc >= 0)) break;
      @(negedge clk_in);
    end
  endtask

  task automatic hold_ready_low(input int cycles);
    @(negedge clk_in);  // controller is on the bus by now
    rdy_in = 1'b0;
    repeat (cycles) begin
      @(negedge clk_in);
      if (fetch_done || ls_done || mem_wr) begin
        report_failure("done pulse or mem_wr seen while rdy_in was low");
      end
    end
    rdy_in = 1'b1;
  endtask

  task automatic check_store_window(input logic [31:0] base);
    logic [31:0] a;
    for (int d = -4; d < 8; d++) begin
      a = base + 32'(d);
      compare_word($sformatf("ram[%h]", a[`RAM_ADDR_WIDTH-1:0]), {24'd0, shadow_at(a)},
                   {24'd0, ram_model_inst.mem[a[`RAM_ADDR_WIDTH-1:0]]});
    end
  endtask

  task automatic apply_entry(input stim_t s);
    int          f_cyc;
    int          l_cyc;
    int unsigned reads;
    logic        need_f;
    logic        need_l;
    logic [31:0] a;
    need_f     = (s.kind == FETCH) || (s.kind == BOTH);
    need_l     = (s.kind != FETCH);
    reads      = ram_model_inst.read_count;
    fetch_en   = need_f;
    fetch_addr = s.f_addr;
    ls_en      = need_l;
    ls_op      = s.op;
    ls_addr    = s.l_addr;
    ls_wdata   = s.wdata;
    @(negedge clk_in);
    fetch_en = 1'b0;
    ls_en    = 1'b0;
    if (s.kind == FROZEN) hold_ready_low(6);
    wait_for_done(need_f, need_l, f_cyc, l_cyc);
    if (need_f) begin
      if (f_cyc < 0) report_failure($sformatf("no fetch_done for address %h", s.f_addr));
      else compare_word("fetch_data", word_at(s.f_addr), fetch_data);
      if (s.hit && f_cyc != 0) report_failure("cache hit did not answer in one cycle");
      if (s.kind == FETCH && s.hit && ram_model_inst.read_count != reads) begin
        report_failure("RAM was read during a cache hit");
      end
      if (s.kind == FETCH && !s.hit && ram_model_inst.read_count == reads) begin
        report_failure("cache miss did not read the RAM");
      end
    end
    if (need_l) begin
      if (l_cyc < 0) begin
        report_failure($sformatf("no ls_done for address %h", s.l_addr));
      end else if (store_bytes(s.op) == 0) begin
        compare_word("ls_rdata", expected_load(s.op, s.l_addr), ls_rdata);
      end else begin
        for (int k = 0; k < store_bytes(s.op); k++) begin
          a = s.l_addr + 32'(k);
          shadow[a[`RAM_ADDR_WIDTH-1:0]] = s.wdata[k*8 +: 8];
        end
        compare_word("ls_rdata", 32'd0, ls_rdata);
        check_store_window(s.l_addr);
      end
    end
  endtask

  initial begin
    int unsigned limit_ns;
    wait (table_ready);
    limit_ns = (stim.size() * (DONE_TIMEOUT + 10) + 100) * CLK_PERIOD;
    #(limit_ns);
    $display("watchdog expired before the stimulus table finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed       = 32'hc8b5ca37;
    errors     = 0;
    checks     = 0;
    rst_in     = 1'b1;
    rdy_in     = 1'b1;
    fetch_en   = 1'b0;
    fetch_addr = '0;
    ls_en      = 1'b0;
    ls_op      = LB;
    ls_addr    = '0;
    ls_wdata   = '0;
    for (int i = 0; i < RAM_BYTES; i++) shadow[i] = rule_byte(i);
    build_stimulus();
    table_ready = 1'b1;
    repeat (3) @(posedge clk_in);
    @(negedge clk_in);
    checks++;
    if (mem_wr || fetch_done || ls_done) report_failure("mem_wr or a done output high in reset");
    rst_in = 1'b0;
    foreach (stim[i]) apply_entry(stim[i]);
    repeat (2) @(negedge clk_in);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: design/ins_cache.sv
// direct-mapped instruction cache, refills whole blocks through the memory controller
`timescale 1ns/1ps
`include "mem_consts.svh"

module ins_cache (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    rdy_in,
  input  logic                    fetch_en,
  input  logic [`ADDR_WIDTH-1:0]  fetch_addr,
  output logic                    fetch_done,
  output logic [`WORD_WIDTH-1:0]  fetch_data,
  output logic                    ic_req,
  output logic [`ADDR_WIDTH-1:0]  ic_addr,
  input  logic                    ic_done,
  input  logic [`BLOCK_BITS-1:0]  ic_block
);

  logic [`BLOCK_NUM-1:0]   valid;
  logic [`TAG_WIDTH-1:0]   tag_mem [`BLOCK_NUM];
  logic [`BLOCK_BITS-1:0]  data_mem [`BLOCK_NUM];

  logic [`ADDR_WIDTH-1:0]  miss_addr;  // fetch waiting on a refill
  logic [`CACHE_WIDTH-1:0] idx;
  logic [`CACHE_WIDTH-1:0] miss_idx;
  logic [`TAG_WIDTH-1:0]   tag;
  logic [`TAG_WIDTH-1:0]   miss_tag;
  logic                    hit;
  logic                    refill;

  // word inside a block, picked by the low address bits above the byte offset
  function automatic logic [`WORD_WIDTH-1:0] pick_word(
    input logic [`BLOCK_BITS-1:0] blk,
    input logic [`ADDR_WIDTH-1:0] a
  );
    return blk[a[`OFFSET_WIDTH-1:2] * `WORD_WIDTH +: `WORD_WIDTH];
  endfunction

  assign idx      = fetch_addr[`OFFSET_WIDTH +: `CACHE_WIDTH];
  assign tag      = fetch_addr[`ADDR_WIDTH-1 -: `TAG_WIDTH];
  assign miss_idx = miss_addr[`OFFSET_WIDTH +: `CACHE_WIDTH];
  assign miss_tag = miss_addr[`ADDR_WIDTH-1 -: `TAG_WIDTH];
  assign hit      = valid[idx] && (tag_mem[idx] == tag);
  assign refill   = ic_req && ic_done;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid      <= '0;
      ic_req     <= 1'b0;
      fetch_done <= 1'b0;
    end else if (rdy_in) begin
      fetch_done <= 1'b0;
      if (refill) begin
        ic_req          <= 1'b0;
        valid[miss_idx] <= 1'b1;
        fetch_done      <= 1'b1;
        fetch_data      <= pick_word(ic_block, miss_addr);
      end else if (fetch_en) begin
        if (hit) begin
          fetch_done <= 1'b1;
          fetch_data <= pick_word(data_mem[idx], fetch_addr);
        end else begin
          ic_req    <= 1'b1;  // held until the controller answers
          ic_addr   <= {fetch_addr[`ADDR_WIDTH-1:`OFFSET_WIDTH], {`OFFSET_WIDTH{1'b0}}};
          miss_addr <= fetch_addr;
        end
      end
    end
  end

  // tag and data arrays
  always_ff @(posedge clk_in) begin
    if (rdy_in && refill) begin
      tag_mem[miss_idx]  <= miss_tag;
      data_mem[miss_idx] <= ic_block;
    end
  end

endmodule

// File: design/ls_port.sv
// load/store port, decodes RISC-V memory opcodes and extends load results
`timescale 1ns/1ps
`include "mem_consts.svh"

module ls_port (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    rdy_in,
  input  logic                    ls_en,
  input  mem_pkg::ls_op_t         ls_op,
  input  logic [`ADDR_WIDTH-1:0]  ls_addr,
  input  logic [`WORD_WIDTH-1:0]  ls_wdata,
  output logic                    ls_done,
  output logic [`WORD_WIDTH-1:0]  ls_rdata,
  output logic                    lsb_req,
  output logic                    lsb_wr,
  output mem_pkg::byte_count_t    lsb_len,
  output logic [`ADDR_WIDTH-1:0]  lsb_addr,
  output logic [`WORD_WIDTH-1:0]  lsb_wdata,
  input  logic                    lsb_done,
  input  logic [`WORD_WIDTH-1:0]  lsb_rdata
);
  import mem_pkg::*;

  ls_op_t                 op_q;      // kept for the extension step
  logic [`WORD_WIDTH-1:0] ext_data;

  always_comb begin
    case (op_q)
      LB:      ext_data = {{24{lsb_rdata[7]}}, lsb_rdata[7:0]};
      LH:      ext_data = {{16{lsb_rdata[15]}}, lsb_rdata[15:0]};
      LW:      ext_data = lsb_rdata;
      LBU:     ext_data = {24'd0, lsb_rdata[7:0]};
      LHU:     ext_data = {16'd0, lsb_rdata[15:0]};
      default: ext_data = '0;  // stores return nothing
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      lsb_req <= 1'b0;
      ls_done <= 1'b0;
      op_q    <= LB;
    end else if (rdy_in) begin
      ls_done <= 1'b0;
      if (lsb_req && lsb_done) begin
        lsb_req  <= 1'b0;
        ls_done  <= 1'b1;
        ls_rdata <= ext_data;
      end else if (ls_en) begin
        lsb_req   <= 1'b1;
        op_q      <= ls_op;
        lsb_addr  <= ls_addr;
        lsb_wdata <= ls_wdata;
        lsb_wr    <= (ls_op == SB) || (ls_op == SH) || (ls_op == SW);
        case (ls_op)
          LB, LBU, SB: lsb_len <= 3'd1;
          LH, LHU, SH: lsb_len <= 3'd2;
          default:     lsb_len <= 3'd4;  // word access
        endcase
      end
    end
  end

endmodule

// File: design/mem_consts.svh
// shared widths and cache geometry for the memory side, include in any file using them
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// bus and data widths
`define ADDR_WIDTH 32
`define WORD_WIDTH 32
`define BYTE_WIDTH 8

// cache geometry
`define BLOCK_WIDTH 1                          // log2 instructions per block
`define BLOCK_BYTES 8                          // bytes fetched per refill
`define BLOCK_BITS 64
`define CACHE_WIDTH 8                          // log2 block count
`define BLOCK_NUM (1 << `CACHE_WIDTH)
`define OFFSET_WIDTH (`BLOCK_WIDTH + 2)        // byte offset inside a block
`define TAG_WIDTH (`ADDR_WIDTH - `CACHE_WIDTH - `OFFSET_WIDTH)

// only the low address bits reach the RAM
`define RAM_ADDR_WIDTH 18

`endif

// File: design/mem_ctrl.sv
// arbiter and byte sequencer in front of the single byte-wide RAM port
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_ctrl (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         rdy_in,
  input  logic [`BYTE_WIDTH-1:0]       mem_din,
  output logic [`BYTE_WIDTH-1:0]       mem_dout,
  output logic [`ADDR_WIDTH-1:0]       mem_a,
  output logic                         mem_wr,
  input  logic                         ic_req,
  input  logic [`ADDR_WIDTH-1:0]       ic_addr,
  output logic                         ic_done,
  output logic [`BLOCK_BITS-1:0]       ic_block,
  input  logic                         lsb_req,
  input  logic                         lsb_wr,
  input  mem_pkg::byte_count_t         lsb_len,
  input  logic [`ADDR_WIDTH-1:0]       lsb_addr,
  input  logic [`WORD_WIDTH-1:0]       lsb_wdata,
  output logic                         lsb_done,
  output logic [`WORD_WIDTH-1:0]       lsb_rdata
);
  import mem_pkg::*;

  mc_state_t                state;
  requester_t               cur_req;     // owner of the running access
  requester_t               last_serve;
  logic [3:0]               step;        // byte currently on the bus
  logic [3:0]               next_step;
  logic [3:0]               req_len;
  logic [`ADDR_WIDTH-1:0]   req_addr;
  logic [`ADDR_WIDTH-1:0]   next_addr;
  logic [`WORD_WIDTH-1:0]   wdata_q;
  logic [`BLOCK_BITS-1:0]   blk_buf;     // gathered read bytes, little endian
  logic [2:0]               cap_idx;
  logic [1:0]               wr_idx;
  logic                     ic_valid;
  logic                     lsb_valid;
  logic                     pick_lsb;

  function automatic logic [`ADDR_WIDTH-1:0] ram_addr(input logic [`ADDR_WIDTH-1:0] a);
    return {{(`ADDR_WIDTH - `RAM_ADDR_WIDTH){1'b0}}, a[`RAM_ADDR_WIDTH-1:0]};
  endfunction

  // a request whose done is out this cycle is already finished
  assign ic_valid  = ic_req & ~ic_done;
  assign lsb_valid = lsb_req & ~lsb_done;
  assign pick_lsb  = lsb_valid & (~ic_valid | (last_serve == ICACHE));

  assign next_step = step + 4'd1;
  assign next_addr = req_addr + {{(`ADDR_WIDTH - 4){1'b0}}, next_step};
  assign cap_idx   = 3'(step - 4'd1);  // byte whose data is on mem_din now
  assign wr_idx    = next_step[1:0];

  assign ic_block  = blk_buf;
  assign lsb_rdata = blk_buf[`WORD_WIDTH-1:0];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state      <= IDLE;
      cur_req    <= LSB;
      last_serve <= ICACHE;  // load/store port goes first
      step       <= 4'd0;
      mem_wr     <= 1'b0;
      mem_a      <= '0;
      mem_dout   <= '0;
      ic_done    <= 1'b0;
      lsb_done   <= 1'b0;
    end else if (rdy_in) begin
      ic_done  <= 1'b0;
      lsb_done <= 1'b0;
      case (state)
        IDLE: begin
          step <= 4'd0;
          if (pick_lsb) begin
            cur_req    <= LSB;
            last_serve <= LSB;
            req_addr   <= lsb_addr;
            req_len    <= {1'b0, lsb_len};
            wdata_q    <= lsb_wdata;
            blk_buf    <= '0;
            mem_a      <= ram_addr(lsb_addr);
            if (lsb_wr) begin
              mem_dout <= lsb_wdata[`BYTE_WIDTH-1:0];
              mem_wr   <= 1'b1;
              state    <= WRITE;
            end else begin
              state <= READ;
            end
          end else if (ic_valid) begin
            cur_req    <= ICACHE;
            last_serve <= ICACHE;
            req_addr   <= ic_addr;
            req_len    <= 4'(`BLOCK_BYTES);
            blk_buf    <= '0;
            mem_a      <= ram_addr(ic_addr);
            state      <= READ;
          end
        end
        READ: begin
          if (step != 4'd0) begin
            blk_buf[cap_idx * `BYTE_WIDTH +: `BYTE_WIDTH] <= mem_din;
          end
          if (step == req_len) begin  // last byte just landed
            state <= IDLE;
            if (cur_req == LSB) lsb_done <= 1'b1;
            else ic_done <= 1'b1;
          end else begin
            if (next_step < req_len) mem_a <= ram_addr(next_addr);
            step <= next_step;
          end
        end
        WRITE: begin
          if (next_step < req_len) begin
            mem_a    <= ram_addr(next_addr);
            mem_dout <= wdata_q[wr_idx * `BYTE_WIDTH +: `BYTE_WIDTH];
            step     <= next_step;
          end else begin
            mem_wr   <= 1'b0;
            lsb_done <= 1'b1;  // only the port writes
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: design/mem_pkg.sv
// types shared by the memory controller, instruction cache and load/store port
package mem_pkg;

  // RISC-V load/store flavours as seen by the port
  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } ls_op_t;

  // controller bus phases
  typedef enum logic [1:0] {
    IDLE,
    READ,
    WRITE
  } mc_state_t;

  // who owns the RAM port
  typedef enum logic {
    LSB,
    ICACHE
  } requester_t;

  typedef logic [2:0] byte_count_t;  // 1, 2 or 4

endpackage

// File: design/mem_subsystem.sv
// memory side top, the instruction cache and load/store port sharing one RAM controller
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_subsystem (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    rdy_in,
  input  logic                    fetch_en,
  input  logic [`ADDR_WIDTH-1:0]  fetch_addr,
  output logic                    fetch_done,
  output logic [`WORD_WIDTH-1:0]  fetch_data,
  input  logic                    ls_en,
  input  mem_pkg::ls_op_t         ls_op,
  input  logic [`ADDR_WIDTH-1:0]  ls_addr,
  input  logic [`WORD_WIDTH-1:0]  ls_wdata,
  output logic                    ls_done,
  output logic [`WORD_WIDTH-1:0]  ls_rdata,
  input  logic [`BYTE_WIDTH-1:0]  mem_din,
  output logic [`BYTE_WIDTH-1:0]  mem_dout,
  output logic [`ADDR_WIDTH-1:0]  mem_a,
  output logic                    mem_wr
);
  import mem_pkg::*;

  // cache to controller
  logic                    ic_req;
  logic [`ADDR_WIDTH-1:0]  ic_addr;
  logic                    ic_done;
  logic [`BLOCK_BITS-1:0]  ic_block;

  // port to controller
  logic                    lsb_req;
  logic                    lsb_wr;
  byte_count_t             lsb_len;
  logic [`ADDR_WIDTH-1:0]  lsb_addr;
  logic [`WORD_WIDTH-1:0]  lsb_wdata;
  logic                    lsb_done;
  logic [`WORD_WIDTH-1:0]  lsb_rdata;

  mem_ctrl mem_ctrl_inst (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .mem_din   (mem_din),
    .mem_dout  (mem_dout),
    .mem_a     (mem_a),
    .mem_wr    (mem_wr),
    .ic_req    (ic_req),
    .ic_addr   (ic_addr),
    .ic_done   (ic_done),
    .ic_block  (ic_block),
    .lsb_req   (lsb_req),
    .lsb_wr    (lsb_wr),
    .lsb_len   (lsb_len),
    .lsb_addr  (lsb_addr),
    .lsb_wdata (lsb_wdata),
    .lsb_done  (lsb_done),
    .lsb_rdata (lsb_rdata)
  );

  ins_cache ins_cache_inst (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_in     (rdy_in),
    .fetch_en   (fetch_en),
    .fetch_addr (fetch_addr),
    .fetch_done (fetch_done),
    .fetch_data (fetch_data),
    .ic_req     (ic_req),
    .ic_addr    (ic_addr),
    .ic_done    (ic_done),
    .ic_block   (ic_block)
  );

  ls_port ls_port_inst (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .ls_en     (ls_en),
    .ls_op     (ls_op),
    .ls_addr   (ls_addr),
    .ls_wdata  (ls_wdata),
    .ls_done   (ls_done),
    .ls_rdata  (ls_rdata),
    .lsb_req   (lsb_req),
    .lsb_wr    (lsb_wr),
    .lsb_len   (lsb_len),
    .lsb_addr  (lsb_addr),
    .lsb_wdata (lsb_wdata),
    .lsb_done  (lsb_done),
    .lsb_rdata (lsb_rdata)
  );

endmodule

// File: project.f
+incdir+design
design/mem_pkg.sv
design/mem_ctrl.sv
design/ins_cache.sv
design/ls_port.sv
design/mem_subsystem.sv
bench/ram_model.sv
bench/tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_mem_subsystem -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
